/* design/dct_settings.svh */
`ifndef DCT_SETTINGS_SVH
`define DCT_SETTINGS_SVH

// Block geometry and sample width
`define DCT_N 8
`define PIX_W 8

// Cosine coefficients are scaled by 2^14
`define COEF_W 16
`define FRAC_BITS 14

// Datapath widths
`define ROW_ACC_W 25
`define ROW_W 11
`define COL_ACC_W 32
`define OUT_W 12

// Sum of 128 * 5793 over the eight taps of the DC row
`define DC_OFFSET 5932032

`endif

/* design/dct_pkg.sv */
`include "dct_settings.svh"

package dct_pkg;

	typedef logic [`PIX_W-1:0] pix_t;
	typedef logic [$clog2(`DCT_N)-1:0] idx_t;
	typedef logic signed [`COEF_W-1:0] coef_t;
	typedef logic signed [`ROW_ACC_W-1:0] row_acc_t;
	typedef logic signed [`ROW_W-1:0] row_val_t;
	typedef row_val_t [`DCT_N-1:0] row_vec_t;
	typedef logic signed [`COL_ACC_W-1:0] col_acc_t;
	typedef logic signed [`OUT_W-1:0] out_t;
	typedef out_t [`DCT_N-1:0][`DCT_N-1:0] out_block_t;

	localparam idx_t LAST_IDX = idx_t'(`DCT_N - 1);

	// Row k holds frequency k, column n holds sample position n
	localparam coef_t DCT_T [`DCT_N][`DCT_N] = '{
		'{ 16'sd5793,  16'sd5793,  16'sd5793,  16'sd5793,
		   16'sd5793,  16'sd5793,  16'sd5793,  16'sd5793},
		'{ 16'sd8035,  16'sd6811,  16'sd4551,  16'sd1598,
		  -16'sd1598, -16'sd4551, -16'sd6811, -16'sd8035},
		'{ 16'sd7568,  16'sd3135, -16'sd3135, -16'sd7568,
		  -16'sd7568, -16'sd3135,  16'sd3135,  16'sd7568},
		'{ 16'sd6811, -16'sd1598, -16'sd8035, -16'sd4551,
		   16'sd4551,  16'sd8035,  16'sd1598, -16'sd6811},
		'{ 16'sd5793, -16'sd5793, -16'sd5793,  16'sd5793,
		   16'sd5793, -16'sd5793, -16'sd5793,  16'sd5793},
		'{ 16'sd4551, -16'sd8035,  16'sd1598,  16'sd6811,
		  -16'sd6811, -16'sd1598,  16'sd8035, -16'sd4551},
		'{ 16'sd3135, -16'sd7568,  16'sd7568, -16'sd3135,
		  -16'sd3135,  16'sd7568, -16'sd7568,  16'sd3135},
		'{ 16'sd1598, -16'sd4551,  16'sd6811, -16'sd8035,
		   16'sd8035, -16'sd6811,  16'sd4551, -16'sd1598}
	};

	// Drop the fraction bits and round half up on the highest dropped bit
	function automatic col_acc_t round_frac(input col_acc_t val);
		col_acc_t half;
		half = col_acc_t'(val[`FRAC_BITS-1]);
		return (val >>> `FRAC_BITS) + half;
	endfunction

endpackage

/* design/dct_ctrl_if.sv */
`timescale 1ns/1ps
`include "dct_settings.svh"

interface dct_ctrl_if import dct_pkg::*; ();

	logic mac_en;
	idx_t pix_col;
	logic row_done;
	logic col_en;
	idx_t col_row;
	logic block_done;

	modport ctrl (output mac_en, pix_col, row_done, col_en, col_row, block_done);

	modport row (input mac_en, pix_col, row_done);

	modport col (input col_en, col_row, block_done);

endinterface

/* design/dct_ctrl.sv */
`timescale 1ns/1ps
`include "dct_settings.svh"

module dct_ctrl import dct_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	dct_ctrl_if.ctrl ctl
);

	idx_t col_cnt;
	idx_t row_cnt;
	logic last_col;

	assign last_col = pix_valid && (col_cnt == LAST_IDX);

	// The row stage consumes a pixel on every accepting edge
	assign ctl.mac_en = pix_valid;
	assign ctl.pix_col = col_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pix_valid) begin
			col_cnt <= col_cnt + 1'b1;
			if (col_cnt == LAST_IDX) begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	// Strobe chain row_done -> col_en -> block_done, one cycle per step
	always_ff @(posedge clk) begin
		if (rst) begin
			ctl.row_done <= 1'b0;
			ctl.col_en <= 1'b0;
			ctl.col_row <= '0;
			ctl.block_done <= 1'b0;
		end else begin
			ctl.row_done <= last_col;
			ctl.col_en <= ctl.row_done;
			ctl.block_done <= ctl.col_en && (ctl.col_row == LAST_IDX);
			// The row counter has already moved on while row_done is high
			if (ctl.row_done) begin
				ctl.col_row <= row_cnt - 1'b1;
			end
		end
	end

	// Each column pass must be preceded by a completed row, and it names that row
	a_col_en_after_row_done: assert property (
		@(posedge clk) disable iff (rst)
		ctl.col_en |-> $past(last_col, 2) && (ctl.col_row == $past(row_cnt, 2))
	);

endmodule

/* design/dct_row_stage.sv */
`timescale 1ns/1ps
`include "dct_settings.svh"

module dct_row_stage import dct_pkg::*; (
	input logic clk,
	input logic rst,
	input pix_t pix_data,
	dct_ctrl_if.row ctl,
	output row_vec_t row_vec
);

	row_acc_t acc [`DCT_N];
	row_acc_t prod [`DCT_N];
	row_acc_t centred [`DCT_N];

	// Pixels are unsigned, so widen with a zero before the signed multiply
	always_comb begin
		for (int u = 0; u < `DCT_N; u++) begin
			prod[u] = row_acc_t'($signed({1'b0, pix_data})) *
				row_acc_t'(DCT_T[u][ctl.pix_col]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int u = 0; u < `DCT_N; u++) begin
				acc[u] <= '0;
			end
		end else if (ctl.mac_en) begin
			for (int u = 0; u < `DCT_N; u++) begin
				// Column 0 starts a new row, so load rather than add
				if (ctl.pix_col == '0) begin
					acc[u] <= prod[u];
				end else begin
					acc[u] <= acc[u] + prod[u];
				end
			end
		end
	end

	// Only the DC term carries the 128 bias of the pixels
	// The other cosine rows sum to zero over a row
	always_comb begin
		for (int u = 0; u < `DCT_N; u++) begin
			centred[u] = acc[u];
		end
		centred[0] = acc[0] - row_acc_t'(`DC_OFFSET);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			row_vec <= '0;
		end else if (ctl.row_done) begin
			for (int u = 0; u < `DCT_N; u++) begin
				row_vec[u] <= row_val_t'(round_frac(col_acc_t'(centred[u])));
			end
		end
	end

endmodule

/* design/dct_col_stage.sv */
`timescale 1ns/1ps
`include "dct_settings.svh"

module dct_col_stage import dct_pkg::*; (
	input logic clk,
	input logic rst,
	input row_vec_t row_vec,
	dct_ctrl_if.col ctl,
	output logic block_valid,
	output out_block_t block_coef
);

	col_acc_t acc [`DCT_N][`DCT_N];
	col_acc_t prod [`DCT_N][`DCT_N];

	// Row r contributes row_vec[u] weighted by column r of the cosine table
	always_comb begin
		for (int u = 0; u < `DCT_N; u++) begin
			for (int v = 0; v < `DCT_N; v++) begin
				prod[u][v] = col_acc_t'($signed(row_vec[u])) *
					col_acc_t'(DCT_T[v][ctl.col_row]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int u = 0; u < `DCT_N; u++) begin
				for (int v = 0; v < `DCT_N; v++) begin
					acc[u][v] <= '0;
				end
			end
		end else if (ctl.col_en) begin
			for (int u = 0; u < `DCT_N; u++) begin
				for (int v = 0; v < `DCT_N; v++) begin
					if (ctl.col_row == '0) begin
						acc[u][v] <= prod[u][v];
					end else begin
						acc[u][v] <= acc[u][v] + prod[u][v];
					end
				end
			end
		end
	end

	// The output block holds until the next block completes
	always_ff @(posedge clk) begin
		if (rst) begin
			block_valid <= 1'b0;
			block_coef <= '0;
		end else begin
			block_valid <= ctl.block_done;
			if (ctl.block_done) begin
				for (int u = 0; u < `DCT_N; u++) begin
					for (int v = 0; v < `DCT_N; v++) begin
						block_coef[u][v] <= out_t'(round_frac(acc[u][v]));
					end
				end
			end
		end
	end

	// The block is only complete once the last row has been folded in
	a_block_done_after_last_row: assert property (
		@(posedge clk) disable iff (rst)
		ctl.block_done |-> $past(ctl.col_en && (ctl.col_row == LAST_IDX))
	);

	a_block_valid_pulse: assert property (
		@(posedge clk) disable iff (rst)
		block_valid |=> !block_valid
	);

endmodule

/* design/dct_top.sv */
`timescale 1ns/1ps
`include "dct_settings.svh"

module dct_top import dct_pkg::*; (
	input logic clk,
	input logic rst,
	input logic pix_valid,
	input pix_t pix_data,
	output logic block_valid,
	output out_block_t block_coef
);

	dct_ctrl_if ctl_if ();

	// One rounded 1-D row transform, passed from row stage to column stage
	row_vec_t row_vec;

	dct_ctrl u_dct_ctrl (
		.clk (clk),
		.rst (rst),
		.pix_valid (pix_valid),
		.ctl (ctl_if.ctrl)
	);

	dct_row_stage u_dct_row_stage (
		.clk (clk),
		.rst (rst),
		.pix_data (pix_data),
		.ctl (ctl_if.row),
		.row_vec (row_vec)
	);

	dct_col_stage u_dct_col_stage (
		.clk (clk),
		.rst (rst),
		.row_vec (row_vec),
		.ctl (ctl_if.col),
		.block_valid (block_valid),
		.block_coef (block_coef)
	);

endmodule

/* dv/dct_tb.sv */
`timescale 1ns/1ps
`include "dct_settings.svh"

module dct_tb import dct_pkg::*; ();

	typedef pix_t pix_block_t [`DCT_N * `DCT_N];

	logic clk;
	logic rst;
	logic pix_valid;
	pix_t pix_data;
	logic block_valid;
	out_block_t block_coef;

	integer seed;
	int cycle_cnt = 0;
	int sent_count;
	int rcv_count;
	out_block_t exp_block_q [$];
	int exp_cycle_q [$];
	out_block_t last_block;

	dct_top u_dct_top (
		.clk (clk),
		.rst (rst),
		.pix_valid (pix_valid),
		.pix_data (pix_data),
		.block_valid (block_valid),
		.block_coef (block_coef)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// Shift out the fraction bits, then add the highest dropped bit
	function automatic longint round_half_up(input longint x);
		return (x >>> `FRAC_BITS) + longint'(x[`FRAC_BITS-1]);
	endfunction

	function automatic out_block_t dct_ref(input pix_block_t pix);
		longint row_val [`DCT_N][`DCT_N];
		longint sum;
		out_block_t res;
		for (int r = 0; r < `DCT_N; r++) begin
			for (int u = 0; u < `DCT_N; u++) begin
				sum = 0;
				for (int c = 0; c < `DCT_N; c++) begin
					sum += longint'(pix[r*`DCT_N + c]) * longint'(DCT_T[u][c]);
				end
				if (u == 0) begin
					sum -= longint'(`DC_OFFSET);
				end
				row_val[r][u] = round_half_up(sum);
			end
		end
		for (int u = 0; u < `DCT_N; u++) begin
			for (int v = 0; v < `DCT_N; v++) begin
				sum = 0;
				for (int r = 0; r < `DCT_N; r++) begin
					sum += row_val[r][u] * longint'(DCT_T[v][r]);
				end
				res[u][v] = out_t'(round_half_up(sum));
			end
		end
		return res;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_coef(input out_t expected, input out_t actual,
		input int u, input int v);
		if (actual !== expected) begin
			stop_on_error($sformatf(
				"CHECK FAILED at %0t: coefficient [%0d][%0d] is %0d, expected %0d",
				$time, u, v, actual, expected));
		end
	endtask

	task automatic check_valid(input logic expected, input logic actual, input string message);
		if (actual !== expected) begin
			stop_on_error($sformatf("CHECK FAILED at %0t: %s (got %b, expected %b)",
				$time, message, actual, expected));
		end
	endtask

	// Drives one block, with up to max_gap idle cycles before each pixel
	task automatic send_block(input pix_block_t blk, input int max_gap);
		int gap;
		for (int i = 0; i < `DCT_N * `DCT_N; i++) begin
			gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
			repeat (gap) begin
				pix_valid = 1'b0;
				@(negedge clk);
			end
			pix_valid = 1'b1;
			pix_data = blk[i];
			if (i == `DCT_N * `DCT_N - 1) begin
				// Accepted on the next edge, block_valid follows 3 edges later
				exp_block_q.push_back(dct_ref(blk));
				exp_cycle_q.push_back(cycle_cnt + 4);
				sent_count++;
			end
			@(negedge clk);
		end
		pix_valid = 1'b0;
	endtask

	task automatic wait_drained(input string what);
		int waited;
		waited = 0;
		while (rcv_count != sent_count) begin
			@(negedge clk);
			waited++;
			if (waited > 200) begin
				stop_on_error($sformatf("Timed out: block_valid never came for the %s", what));
			end
		end
	endtask

	// A pulse is expected exactly on the cycle queued for the oldest block
	initial begin
		logic due;
		out_block_t expected;
		forever begin
			@(negedge clk);
			due = (exp_cycle_q.size() > 0) && (exp_cycle_q[0] == cycle_cnt);
			check_valid(due, block_valid, "block_valid pulse timing");
			if (due) begin
				expected = exp_block_q.pop_front();
				void'(exp_cycle_q.pop_front());
				for (int u = 0; u < `DCT_N; u++) begin
					for (int v = 0; v < `DCT_N; v++) begin
						check_coef(expected[u][v], block_coef[u][v], u, v);
					end
				end
				last_block = block_coef;
				rcv_count++;
			end
		end
	end

	initial begin
		pix_block_t blk;
		seed = 35968;
		sent_count = 0;
		rcv_count = 0;
		rst = 1'b1;
		pix_valid = 1'b0;
		pix_data = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		repeat (10) @(negedge clk);

		// A flat mid-grey block has no energy at all
		for (int i = 0; i < `DCT_N * `DCT_N; i++) begin
			blk[i] = 8'd128;
		end
		send_block(blk, 0);
		wait_drained("all-128 block");
		for (int u = 0; u < `DCT_N; u++) begin
			for (int v = 0; v < `DCT_N; v++) begin
				check_coef('0, last_block[u][v], u, v);
			end
		end

		for (int i = 0; i < `DCT_N * `DCT_N; i++) begin
			blk[i] = 8'd255;
		end
		send_block(blk, 0);
		wait_drained("all-255 block");
		for (int u = 0; u < `DCT_N; u++) begin
			for (int v = 0; v < `DCT_N; v++) begin
				if (u != 0 || v != 0) begin
					check_coef('0, last_block[u][v], u, v);
				end
			end
		end
		check_valid(1'b1, last_block[0][0] != '0, "DC term of the all-255 block is nonzero");

		for (int b = 0; b < 20; b++) begin
			for (int i = 0; i < `DCT_N * `DCT_N; i++) begin
				blk[i] = pix_t'($random(seed));
			end
			send_block(blk, 0);
		end
		wait_drained("back-to-back random blocks");

		for (int b = 0; b < 6; b++) begin
			for (int i = 0; i < `DCT_N * `DCT_N; i++) begin
				blk[i] = pix_t'($random(seed));
			end
			send_block(blk, 3);
		end
		wait_drained("random blocks with idle gaps");

		// Any extra pulse here is caught by the monitor
		repeat (20) @(negedge clk);

		if (rcv_count == sent_count) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+design
design/dct_pkg.sv
design/dct_ctrl_if.sv
design/dct_ctrl.sv
design/dct_row_stage.sv
design/dct_col_stage.sv
design/dct_top.sv
dv/dct_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the DCT testbench with Verilator, pass or fail taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module dct_tb \
	-o dct_sim --Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/dct_sim > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
